/* src/selftrig_pkg.sv */
// shared widths, types and controller states for the self-trigger bookkeeping, imported by all RTL
`default_nettype none

package selftrig_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------

    localparam int num_chan       = 5;  // channel FPGAs on the board
    localparam int trig_num_w     = 24; // running trigger number
    localparam int selftrig_cnt_w = 20; // triggers per DDR3 buffer
    localparam int burst_w        = 23; // burst totals and overflow threshold

    // ----------------------------------------
    // vector types
    // ----------------------------------------

    // one bit per channel
    // used for enables, dones, trigger pulses, warnings
    typedef logic [num_chan-1:0] chan_mask_t;

    typedef logic [trig_num_w-1:0]     trig_num_t;     // per-channel trigger number
    typedef logic [selftrig_cnt_w-1:0] selftrig_cnt_t; // per-buffer trigger count
    typedef logic [burst_w-1:0]        burst_cnt_t;    // bursts, totals, threshold

    // ----------------------------------------
    // controller states
    // ----------------------------------------

    typedef enum logic [1:0] {
        idle     = 2'd0, // channels off, waiting for accept
        armed    = 2'd1, // channels taking self triggers
        draining = 2'd2, // channels off, waiting for all dones
        swapping = 2'd3  // single cycle, write buffer flips
    } swap_state_t;

    // ----------------------------------------
    // channel status
    // ----------------------------------------

    // everything one channel counter reports upward
    typedef struct packed {
        trig_num_t     trig_num;     // triggers since last number reset
        selftrig_cnt_t selftrig_lo;  // triggers stored in lo buffer
        selftrig_cnt_t selftrig_hi;  // triggers stored in hi buffer
        burst_cnt_t    bursts_write; // bursts in the current write buffer
        logic          almost_full;  // write buffer at or over threshold
    } chan_status_t;

    // element i belongs to channel i
    typedef chan_status_t [num_chan-1:0] chan_status_vec_t;

endpackage

`default_nettype wire

/* src/chan_input_sync.sv */
// brings the channel trigger, done and enable lines into ttc_clk; triggers become rising-edge pulses
`timescale 1ns/100ps
`default_nettype none

module chan_input_sync (
    input  logic                     ttc_clk,
    input  logic                     arst_n,
    input  selftrig_pkg::chan_mask_t chan_trigs, // async trigger levels from channels
    input  selftrig_pkg::chan_mask_t chan_dones, // async done levels
    input  selftrig_pkg::chan_mask_t chan_en,    // async enable mask
    output selftrig_pkg::chan_mask_t trig_pulse, // one cycle per rising trigger
    output selftrig_pkg::chan_mask_t dones_sync,
    output selftrig_pkg::chan_mask_t en_sync
);
    import selftrig_pkg::*;

    chan_mask_t trig_s1; // metastable stage
    chan_mask_t trig_s2;
    chan_mask_t trig_s3; // previous synced value, for the edge
    chan_mask_t done_s1;
    chan_mask_t done_s2;
    chan_mask_t en_s1;
    chan_mask_t en_s2;

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            trig_s1 <= '0;
            trig_s2 <= '0;
            trig_s3 <= '0;
            done_s1 <= '0;
            done_s2 <= '0;
            en_s1   <= '0;
            en_s2   <= '0;
        end else begin
            trig_s1 <= chan_trigs;
            trig_s2 <= trig_s1;
            trig_s3 <= trig_s2;
            done_s1 <= chan_dones; // plain 2-flop sync
            done_s2 <= done_s1;
            en_s1   <= chan_en;
            en_s2   <= en_s1;
        end
    end

    assign trig_pulse = trig_s2 & ~trig_s3; // new high after a low
    assign dones_sync = done_s2;
    assign en_sync    = en_s2;

endmodule

`default_nettype wire

/* src/chan_trig_counter.sv */
// one channel's trigger number, lo/hi trigger counts, lo/hi burst totals and overflow warning
`timescale 1ns/100ps
`default_nettype none

module chan_trig_counter (
    input  logic                       ttc_clk,
    input  logic                       arst_n,
    input  logic                       trig_pulse,     // synced self-trigger pulse
    input  logic                       chan_enable,    // this channel may take triggers
    input  logic                       ddr3_buffer,    // write buffer, 0 lo / 1 hi
    input  logic                       buffer_changed, // write buffer just flipped
    input  logic                       rst_trig_num,   // clears trigger number only
    input  selftrig_pkg::burst_cnt_t   burst_count,    // bursts taken by this trigger
    input  selftrig_pkg::burst_cnt_t   thres_overflow, // warning threshold
    output selftrig_pkg::chan_status_t status
);
    import selftrig_pkg::*;

    // saturating add, the total sticks at all ones
    function automatic burst_cnt_t sat_add(input burst_cnt_t total, input burst_cnt_t incr);
        logic [burst_w:0] sum;
        sum = {1'b0, total} + {1'b0, incr};
        if (sum[burst_w]) begin
            return '1;
        end
        return sum[burst_w-1:0];
    endfunction

    trig_num_t     trig_num;
    selftrig_cnt_t selftrig [2]; // index 0 lo, 1 hi
    burst_cnt_t    bursts [2];
    logic          hit;          // counted trigger this cycle

    assign hit = trig_pulse & chan_enable;

    // ----------------------------------------
    // trigger number
    // ----------------------------------------

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            trig_num <= '0;
        end else if (rst_trig_num) begin
            trig_num <= '0; // reset beats a same-cycle trigger
        end else if (hit) begin
            trig_num <= trig_num + 1'b1;
        end
    end

    // ----------------------------------------
    // per-buffer counts
    // ----------------------------------------

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            selftrig[0] <= '0;
            selftrig[1] <= '0;
            bursts[0]   <= '0;
            bursts[1]   <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (buffer_changed && (ddr3_buffer == b[0])) begin
                    // fresh write buffer, the other one keeps its data for readout
                    selftrig[b] <= '0;
                    bursts[b]   <= '0;
                end else if (hit && (ddr3_buffer == b[0])) begin
                    selftrig[b] <= selftrig[b] + 1'b1;
                    bursts[b]   <= sat_add(bursts[b], burst_count);
                end
            end
        end
    end

    // ----------------------------------------
    // status out
    // ----------------------------------------

    assign status.trig_num     = trig_num;
    assign status.selftrig_lo  = selftrig[0];
    assign status.selftrig_hi  = selftrig[1];
    assign status.bursts_write = bursts[ddr3_buffer];
    assign status.almost_full  = (bursts[ddr3_buffer] >= thres_overflow); // level, not latched

endmodule

`default_nettype wire

/* src/buffer_swap_ctrl.sv */
// FSM that enables the channels, answers a backplane trigger with swap or empty event, owns the write buffer
`timescale 1ns/100ps
`default_nettype none

module buffer_swap_ctrl (
    input  logic                      ttc_clk,
    input  logic                      arst_n,
    input  logic                      accept_self_triggers, // run control level
    input  selftrig_pkg::chan_mask_t  chan_en,              // synced enable mask
    input  selftrig_pkg::chan_mask_t  chan_dones,           // synced dones
    input  logic                      ttc_trigger,          // backplane trigger strobe
    input  logic                      selftriggers_seen,    // write buffer not empty
    output selftrig_pkg::chan_mask_t  chan_enable,          // to channel FPGAs
    output logic                      ddr3_buffer,          // 0 lo, 1 hi
    output logic                      readout_buffer_changed,
    output logic                      send_empty_event,
    output selftrig_pkg::swap_state_t state
);
    import selftrig_pkg::*;

    swap_state_t state_nxt;
    logic        all_done;  // every enabled channel has finished
    logic        empty_req; // trigger with nothing stored

    assign all_done  = ((chan_dones & chan_en) == chan_en);
    assign empty_req = (state == armed) && accept_self_triggers
                       && ttc_trigger && !selftriggers_seen;

    // ----------------------------------------
    // next state
    // ----------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (accept_self_triggers && (chan_en != '0)) begin
                    state_nxt = armed;
                end
            end
            armed: begin
                if (!accept_self_triggers) begin
                    state_nxt = idle; // run stopped, trigger ignored
                end else if (ttc_trigger && selftriggers_seen) begin
                    state_nxt = draining;
                end
                // empty buffer stays armed, see empty_req
            end
            draining: begin
                if (all_done) begin
                    state_nxt = swapping;
                end
            end
            swapping: begin
                state_nxt = armed; // one cycle only
            end
            default: begin
                state_nxt = idle;
            end
        endcase
    end

    // ----------------------------------------
    // state and registered outputs
    // ----------------------------------------

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            state                  <= idle;
            chan_enable            <= '0;
            ddr3_buffer            <= 1'b0; // start writing lo
            readout_buffer_changed <= 1'b0;
            send_empty_event       <= 1'b0;
        end else begin
            state <= state_nxt;

            // channels only run while armed
            chan_enable <= (state_nxt == armed) ? chan_en : '0;

            // pulse sits in the swapping cycle, same edge as the flip
            readout_buffer_changed <= (state_nxt == swapping);
            if (state_nxt == swapping) begin
                ddr3_buffer <= ~ddr3_buffer;
            end

            send_empty_event <= empty_req; // one cycle per trigger
        end
    end

endmodule

`default_nettype wire

/* src/selftrig_status.sv */
// combines per-channel status into the triggers-seen flag and the global DDR3 almost-full warning
`timescale 1ns/100ps
`default_nettype none

module selftrig_status (
    input  selftrig_pkg::chan_status_vec_t chan_status,
    input  logic                           ddr3_buffer,       // current write buffer
    output logic                           selftriggers_seen, // any count in write buffer
    output logic                           ddr3_almost_full   // any channel warning
);
    import selftrig_pkg::*;

    chan_mask_t seen_chan; // per channel, write count nonzero
    chan_mask_t full_chan;

    always_comb begin
        for (int i = 0; i < num_chan; i++) begin
            // only the buffer being written matters for the swap decision
            if (ddr3_buffer) begin
                seen_chan[i] = (chan_status[i].selftrig_hi != '0);
            end else begin
                seen_chan[i] = (chan_status[i].selftrig_lo != '0);
            end
            full_chan[i] = chan_status[i].almost_full;
        end
    end

    assign selftriggers_seen = |seen_chan;
    assign ddr3_almost_full  = |full_chan;

endmodule

`default_nettype wire

/* src/selftrigger_top.sv */
// top level of the 40 MHz self-trigger bookkeeping; sync, swap FSM, status reducer, channel counters
`timescale 1ns/100ps
`default_nettype none

module selftrigger_top (
    input  logic                           ttc_clk,              // 40 MHz
    input  logic                           arst_n,
    // channel lines, asynchronous
    input  selftrig_pkg::chan_mask_t       chan_trigs,
    input  selftrig_pkg::chan_mask_t       chan_dones,
    input  selftrig_pkg::chan_mask_t       chan_en,
    // run control and backplane
    input  logic                           accept_self_triggers,
    input  logic                           ttc_trigger,          // ttc_clk strobe
    input  logic                           rst_trigger_num,      // ttc_clk strobe
    input  selftrig_pkg::burst_cnt_t       thres_ddr3_overflow,  // static
    input  selftrig_pkg::burst_cnt_t       burst_count_selftrig, // sampled per trigger
    // to channels and readout
    output selftrig_pkg::chan_mask_t       chan_enable,
    output logic                           ddr3_buffer,
    output logic                           readout_buffer_changed,
    output logic                           send_empty_event,
    // status
    output selftrig_pkg::chan_status_vec_t chan_status,
    output logic                           selftriggers_seen,
    output logic                           ddr3_almost_full,
    output selftrig_pkg::swap_state_t      swap_state
);
    import selftrig_pkg::*;

    chan_mask_t trig_pulse; // synced rising edges
    chan_mask_t dones_sync;
    chan_mask_t en_sync;

    // ----------------------------------------
    // input synchronizers
    // ----------------------------------------

    chan_input_sync i_input_sync (
        .ttc_clk    (ttc_clk),
        .arst_n     (arst_n),
        .chan_trigs (chan_trigs),
        .chan_dones (chan_dones),
        .chan_en    (chan_en),
        .trig_pulse (trig_pulse),
        .dones_sync (dones_sync),
        .en_sync    (en_sync)
    );

    // ----------------------------------------
    // swap controller and status
    // ----------------------------------------

    buffer_swap_ctrl i_swap_ctrl (
        .ttc_clk                (ttc_clk),
        .arst_n                 (arst_n),
        .accept_self_triggers   (accept_self_triggers),
        .chan_en                (en_sync),
        .chan_dones             (dones_sync),
        .ttc_trigger            (ttc_trigger),
        .selftriggers_seen      (selftriggers_seen),
        .chan_enable            (chan_enable),
        .ddr3_buffer            (ddr3_buffer),
        .readout_buffer_changed (readout_buffer_changed),
        .send_empty_event       (send_empty_event),
        .state                  (swap_state)
    );

    selftrig_status i_status (
        .chan_status       (chan_status),
        .ddr3_buffer       (ddr3_buffer),
        .selftriggers_seen (selftriggers_seen),
        .ddr3_almost_full  (ddr3_almost_full)
    );

    // ----------------------------------------
    // one counter per channel
    // ----------------------------------------

    for (genvar i = 0; i < num_chan; i++) begin : g_chan
        chan_trig_counter i_counter (
            .ttc_clk        (ttc_clk),
            .arst_n         (arst_n),
            .trig_pulse     (trig_pulse[i]),
            .chan_enable    (chan_enable[i]),        // gated by the FSM, not raw chan_en
            .ddr3_buffer    (ddr3_buffer),           // all channels share one buffer
            .buffer_changed (readout_buffer_changed),
            .rst_trig_num   (rst_trigger_num),
            .burst_count    (burst_count_selftrig),
            .thres_overflow (thres_ddr3_overflow),
            .status         (chan_status[i])
        );
    end

endmodule

`default_nettype wire

/* bench/selftrig_model.svh */
// reference model of counters, write buffer and overflow warning, included inside the testbench module
`ifndef SELFTRIG_MODEL_SVH
`define SELFTRIG_MODEL_SVH

// ----------------------------------------
// model state
// ----------------------------------------

localparam int unsigned m_burst_max = 32'h007f_ffff; // 23-bit all ones

int unsigned m_trig_num [5];
int unsigned m_cnt [2][5];   // indexed [buffer][channel] with 0 lo and 1 hi
int unsigned m_burst [2][5];
int unsigned m_buf;          // current write buffer
int unsigned m_thres;

function automatic void reset_model();
    for (int i = 0; i < 5; i++) begin
        m_trig_num[i] = 0;
        for (int b = 0; b < 2; b++) begin
            m_cnt[b][i]   = 0;
            m_burst[b][i] = 0;
        end
    end
    m_buf = 0; // lo after reset
endfunction

// mask holds only the channels that really count this trigger
function automatic void count_trigger(input logic [4:0] mask, input int unsigned burst);
    for (int i = 0; i < 5; i++) begin
        if (mask[i]) begin
            m_trig_num[i]++;
            m_cnt[m_buf][i]++;
            if (m_burst[m_buf][i] > m_burst_max - burst) begin
                m_burst[m_buf][i] = m_burst_max; // sticks at the top
            end else begin
                m_burst[m_buf][i] += burst;
            end
        end
    end
endfunction

// new write buffer starts empty while the old one stays for readout
function automatic void swap_write_buffer();
    m_buf = 1 - m_buf;
    for (int i = 0; i < 5; i++) begin
        m_cnt[m_buf][i]   = 0;
        m_burst[m_buf][i] = 0;
    end
endfunction

function automatic void clear_trig_nums();
    for (int i = 0; i < 5; i++) begin
        m_trig_num[i] = 0;
    end
endfunction

// one channel warns at or above the threshold
function automatic bit chan_full(input int i);
    return (m_burst[m_buf][i] >= m_thres);
endfunction

function automatic bit any_chan_full();
    bit full;
    full = 0;
    for (int i = 0; i < 5; i++) begin
        if (chan_full(i)) full = 1; // any channel warns
    end
    return full;
endfunction

`endif

/* bench/selftrig_tb.sv */
// testbench for selftrigger_top; random triggers from an LFSR checked against the included model
`timescale 1ns/100ps
`default_nettype none

module selftrig_tb;
    import selftrig_pkg::*;

    `include "selftrig_model.svh"

    logic ttc_clk;
    logic arst_n;
    chan_mask_t chan_trigs, chan_dones, chan_en;
    logic accept_self_triggers, ttc_trigger, rst_trigger_num;
    burst_cnt_t thres_ddr3_overflow, burst_count_selftrig;
    chan_mask_t chan_enable;
    logic ddr3_buffer, readout_buffer_changed, send_empty_event;
    chan_status_vec_t chan_status;
    logic selftriggers_seen, ddr3_almost_full;
    swap_state_t swap_state;

    logic [31:0] lfsr_state = 32'hba71_c8c4;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int tests_failed = 0;
    int rbc_count = 0;   // readout_buffer_changed pulses seen
    int empty_count = 0; // send_empty_event pulses seen

    selftrigger_top i_dut (.*);

    initial begin
        ttc_clk = 1'b0;
        forever #4 ttc_clk = ~ttc_clk; // 8 ns
    end

    always @(posedge ttc_clk) begin
        if (readout_buffer_changed) rbc_count++;
        if (send_empty_event) empty_count++;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic lsb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) lfsr_state = lfsr_state ^ 32'h8020_0003;
            r = {r[30:0], lsb};
        end
        return r;
    endfunction

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic cycles(input int n);
        repeat (n) @(posedge ttc_clk);
        #1; // drive point
    endtask

    task automatic wait_state(input swap_state_t s, input string what);
        int t;
        t = 0;
        while (swap_state !== s && t < 20) begin
            cycles(1);
            t++;
        end
        if (swap_state !== s) begin
            errors++;
            $display("timeout: controller never reached %s", what);
        end
    endtask

    task automatic compare_all();
        for (int i = 0; i < 5; i++) begin
            check_val(chan_status[i].trig_num, m_trig_num[i], $sformatf("chan %0d trig_num", i));
            check_val(chan_status[i].selftrig_lo, m_cnt[0][i], $sformatf("chan %0d lo count", i));
            check_val(chan_status[i].selftrig_hi, m_cnt[1][i], $sformatf("chan %0d hi count", i));
            check_val(chan_status[i].bursts_write, m_burst[m_buf][i],
                      $sformatf("chan %0d write bursts", i));
            check_val(chan_status[i].almost_full, chan_full(i),
                      $sformatf("chan %0d almost_full", i));
        end
        check_val(ddr3_almost_full, any_chan_full(), "ddr3_almost_full");
        check_val(ddr3_buffer, m_buf, "ddr3_buffer");
    endtask

    // one trigger on mask with high and low phases of 2 or 3 cycles each
    task automatic fire(input chan_mask_t mask, input int unsigned burst, input chan_mask_t counts);
        burst_count_selftrig = burst_cnt_t'(burst); // stays put until the next trigger
        chan_trigs = mask;
        cycles(2 + rand_bits(1));
        chan_trigs = '0;
        cycles(2 + rand_bits(1));
        count_trigger(mask & counts, burst);
    endtask

    task automatic pulse_ttc();
        ttc_trigger = 1'b1;
        cycles(1);
        ttc_trigger = 1'b0;
    endtask

    task automatic do_swap();
        int start;
        int t;
        start = rbc_count;
        pulse_ttc();
        t = 0;
        while (chan_enable !== '0 && t < 10) begin
            cycles(1);
            t++;
        end
        check_val(chan_enable, 0, "chan_enable low while draining");
        chan_dones = chan_en & (chan_en - 1'b1); // all but the lowest enabled
        cycles(6);
        check_val(rbc_count, start, "no swap before all dones");
        chan_dones = chan_en;
        t = 0;
        while (rbc_count == start && t < 20) begin
            cycles(1);
            t++;
        end
        if (rbc_count == start) begin
            errors++;
            $display("timeout: readout_buffer_changed never pulsed");
        end
        cycles(6);
        check_val(rbc_count, start + 1, "one readout_buffer_changed pulse");
        swap_write_buffer();
        chan_dones = '0;
        cycles(6);
        compare_all();
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors != err_before) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // ----------------------------------------
    // sequence
    // ----------------------------------------

    initial begin
        int e;
        int n;
        int start;
        logic old_buf;
        arst_n = 1'b0;
        chan_trigs = '0;
        chan_dones = '0;
        chan_en = '0;
        accept_self_triggers = 1'b0;
        ttc_trigger = 1'b0;
        rst_trigger_num = 1'b0;
        thres_ddr3_overflow = '1;
        burst_count_selftrig = '0;
        reset_model();
        m_thres = m_burst_max;
        repeat (5) @(posedge ttc_clk);
        #1 arst_n = 1'b1;
        cycles(2);

        // counting while armed with channel 4 never enabled
        e = errors;
        chan_en = (chan_mask_t'(rand_bits(5)) | 5'b00001) & 5'b01111;
        accept_self_triggers = 1'b1;
        wait_state(armed, "armed");
        cycles(3);
        check_val(chan_enable, chan_en, "chan_enable follows chan_en while armed");
        for (int k = 0; k < 10; k++) begin
            fire(chan_mask_t'(rand_bits(5)), rand_bits(8), chan_en);
        end
        cycles(6);
        compare_all();
        check_val(selftriggers_seen, 1, "selftriggers_seen");
        end_test("counting", e);

        // disabled channels first and then all channels while idle
        e = errors;
        for (int k = 0; k < 4; k++) begin
            fire(~chan_en, rand_bits(8), chan_en);
        end
        accept_self_triggers = 1'b0;
        wait_state(idle, "idle");
        cycles(2);
        fire('1, rand_bits(8), '0);
        cycles(6);
        compare_all();
        accept_self_triggers = 1'b1;
        wait_state(armed, "armed");
        cycles(3);
        end_test("disabled", e);

        // swap into the empty hi buffer
        e = errors;
        do_swap();
        end_test("swap", e);

        // empty event
        e = errors;
        old_buf = ddr3_buffer;
        start = empty_count;
        pulse_ttc();
        n = 0;
        while (empty_count == start && n < 10) begin
            cycles(1);
            n++;
        end
        if (empty_count == start) begin
            errors++;
            $display("timeout: send_empty_event never pulsed");
        end
        cycles(6);
        check_val(empty_count, start + 1, "one send_empty_event pulse");
        check_val(ddr3_buffer, old_buf, "buffer kept on empty event");
        check_val(swap_state, armed, "still armed");
        end_test("empty_event", e);

        // overflow warning
        e = errors;
        m_thres = 20 + rand_bits(6);
        thres_ddr3_overflow = burst_cnt_t'(m_thres);
        cycles(6);
        n = 0;
        while (!any_chan_full() && n < 40) begin
            fire(chan_en, rand_bits(4), chan_en);
            cycles(6);
            check_val(ddr3_almost_full, any_chan_full(), "almost_full while filling");
            n++;
        end
        check_val(ddr3_almost_full, 1, "almost_full reached");
        do_swap();
        check_val(ddr3_almost_full, 0, "almost_full after swap");
        end_test("overflow", e);

        // trigger number reset
        e = errors;
        rst_trigger_num = 1'b1;
        cycles(1);
        rst_trigger_num = 1'b0;
        clear_trig_nums();
        cycles(6);
        compare_all();
        end_test("trig_num_reset", e);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+bench
src/selftrig_pkg.sv
src/chan_input_sync.sv
src/chan_trig_counter.sv
src/buffer_swap_ctrl.sv
src/selftrig_status.sv
src/selftrigger_top.sv
bench/selftrig_tb.sv

/* Bender.yml */
package:
  name: selftrigger

sources:
  - src/selftrig_pkg.sv
  - src/chan_input_sync.sv
  - src/chan_trig_counter.sv
  - src/buffer_swap_ctrl.sv
  - src/selftrig_status.sv
  - src/selftrigger_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/selftrig_tb.sv
